// File: design/soc_pkg.sv
`default_nettype none

package soc_pkg;

	typedef logic [7:0]  byte_t;   // One UART character
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;   // Byte address
	typedef logic [3:0]  mask_t;   // Bit i enables byte i
	typedef logic [71:0] msg_t;    // Up to nine bytes, byte 0 lowest
	typedef logic [3:0]  msg_len_t;

	// Request code per memory port
	typedef enum logic [1:0]
	{
		op_idle  = 2'd0,
		op_read  = 2'd1,
		op_write = 2'd2
	} mem_op_t;

	localparam byte_t req_read       = 8'h00;
	localparam byte_t req_write_base = 8'h80; // Mask goes in the low nibble

	localparam msg_len_t read_req_len   = 4'd5;
	localparam msg_len_t write_req_len  = 4'd9;
	localparam msg_len_t read_reply_len = 4'd4;

endpackage

`default_nettype wire

// File: design/uart_link.sv
`default_nettype none

module uart_link
	import soc_pkg::*;
#(
	parameter int SAMPLE_INTERVAL = 16
)
(
	input  logic  clk,
	input  logic  rst,
	input  logic  tx_start,
	input  byte_t tx_byte,
	output logic  tx_idle,
	output logic  rx_valid,
	output byte_t rx_byte,
	output logic  tx,
	input  logic  rx
);

	localparam int CW = $clog2(SAMPLE_INTERVAL + 1);
	localparam logic [CW-1:0] bit_last  = CW'(SAMPLE_INTERVAL - 1);
	localparam logic [CW-1:0] half_last = CW'(SAMPLE_INTERVAL / 2 - 1);

	typedef enum logic [1:0] {rs_idle, rs_start, rs_data, rs_stop} rx_state_t;

	logic [9:0]    tx_shift;   // Stop, data, start
	logic [CW-1:0] tx_timer;
	logic [3:0]    tx_count;
	logic          tx_busy;

	logic [1:0]    rx_sync;
	rx_state_t     rx_state;
	logic [CW-1:0] rx_timer;
	logic [2:0]    rx_count;
	byte_t         rx_shift;

	assign tx      = tx_shift[0];
	assign tx_idle = !tx_busy;
	assign rx_byte = rx_shift;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tx_shift <= '1;            // Line idles high
			tx_timer <= '0;
			tx_count <= '0;
			tx_busy  <= 1'b0;
		end
		else if (!tx_busy)
		begin
			if (tx_start)
			begin
				tx_shift <= {1'b1, tx_byte, 1'b0};
				tx_timer <= '0;
				tx_count <= '0;
				tx_busy  <= 1'b1;
			end
		end
		else if (tx_timer == bit_last)
		begin
			tx_timer <= '0;
			tx_shift <= {1'b1, tx_shift[9:1]};
			tx_count <= tx_count + 4'd1;
			if (tx_count == 4'd9)
				tx_busy <= 1'b0;       // End of stop bit
		end
		else
			tx_timer <= tx_timer + 1'b1;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rx_sync  <= 2'b11;
			rx_state <= rs_idle;
			rx_timer <= '0;
			rx_count <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_sync  <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			case (rx_state)
				rs_idle:
				begin
					rx_timer <= '0;
					if (!rx_sync[1])
						rx_state <= rs_start;  // Falling edge of start bit
				end
				rs_start:
				begin
					if (rx_timer == half_last)
					begin
						rx_timer <= '0;
						rx_count <= '0;
						rx_state <= rx_sync[1] ? rs_idle : rs_data; // Glitch check
					end
					else
						rx_timer <= rx_timer + 1'b1;
				end
				rs_data:
				begin
					if (rx_timer == bit_last)
					begin
						rx_timer <= '0;
						rx_count <= rx_count + 3'd1;
						if (rx_count == 3'd7)
							rx_state <= rs_stop;
					end
					else
						rx_timer <= rx_timer + 1'b1;
				end
				default:
				begin
					if (rx_timer == bit_last)
					begin
						rx_timer <= '0;
						rx_state <= rs_idle;
						rx_valid <= rx_sync[1];  // Low stop bit drops the frame
					end
					else
						rx_timer <= rx_timer + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_state == rs_data && rx_timer == bit_last)
			rx_shift <= {rx_sync[1], rx_shift[7:1]}; // LSB first
	end

	// The framer must wait for the transmitter
	a_tx_start_idle: assert property (@(posedge clk) disable iff (rst)
		tx_start |-> tx_idle);

endmodule

`default_nettype wire

// File: design/msg_framer.sv
`default_nettype none

module msg_framer
	import soc_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     msg_send,
	input  msg_t     send_msg,
	input  msg_len_t send_len,
	output logic     send_ready,
	output logic     recv_valid,
	output msg_t     recv_msg,
	output msg_len_t recv_len,
	output logic     tx_start,
	output byte_t    tx_byte,
	input  logic     tx_idle,
	input  logic     rx_valid,
	input  byte_t    rx_byte
);

	typedef enum logic [1:0] {ts_idle, ts_len, ts_payload} send_state_t;
	typedef enum logic {rcv_len, rcv_data} recv_state_t;

	send_state_t send_state;
	msg_t        tx_msg;
	msg_len_t    tx_left;      // Length byte, then bytes still to go

	recv_state_t recv_state;
	msg_t        rx_buf;
	msg_len_t    rx_len;
	msg_len_t    rx_idx;

	assign send_ready = (send_state == ts_idle) && tx_idle;
	assign tx_start   = (send_state != ts_idle) && tx_idle;
	assign tx_byte    = (send_state == ts_len) ? byte_t'(tx_left) : tx_msg[7:0];
	assign recv_msg   = rx_buf;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			send_state <= ts_idle;
			tx_left    <= '0;
		end
		else
		begin
			case (send_state)
				ts_idle:
				begin
					if (msg_send)
					begin
						tx_left    <= send_len;
						send_state <= ts_len;
					end
				end
				ts_len:
				begin
					if (tx_idle)
						send_state <= (tx_left == '0) ? ts_idle : ts_payload;
				end
				default:
				begin
					if (tx_idle)
					begin
						tx_left <= tx_left - 4'd1;
						if (tx_left == 4'd1)
							send_state <= ts_idle;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (send_state == ts_idle && msg_send)
			tx_msg <= send_msg;
		else if (send_state == ts_payload && tx_idle)
			tx_msg <= tx_msg >> 8;         // Next byte to the bottom
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			recv_state <= rcv_len;
			rx_len     <= '0;
			rx_idx     <= '0;
			recv_valid <= 1'b0;
			recv_len   <= '0;
		end
		else
		begin
			recv_valid <= 1'b0;
			if (rx_valid)
			begin
				if (recv_state == rcv_len)
				begin
					rx_len <= msg_len_t'(rx_byte);
					rx_idx <= '0;
					if (msg_len_t'(rx_byte) == '0)
					begin
						recv_valid <= 1'b1;   // Empty message
						recv_len   <= '0;
					end
					else
						recv_state <= rcv_data;
				end
				else
				begin
					rx_idx <= rx_idx + 4'd1;
					if (rx_idx == rx_len - 4'd1)
					begin
						recv_valid <= 1'b1;
						recv_len   <= rx_len;
						recv_state <= rcv_len;
					end
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_valid)
		begin
			if (recv_state == rcv_len)
				rx_buf <= '0;
			else
				rx_buf[rx_idx*8 +: 8] <= rx_byte;
		end
	end

	// Host never sends more than a full message
	a_recv_len_max: assert property (@(posedge clk) disable iff (rst)
		recv_valid |-> recv_len <= 4'd9);

endmodule

`default_nettype wire

// File: design/mem_bridge.sv
`default_nettype none

module mem_bridge
	import soc_pkg::*;
(
	input  logic           clk,
	input  logic           rst,
	input  mem_op_t  [1:0] mem_op,
	input  addr_t    [1:0] mem_addr,
	input  word_t    [1:0] mem_w_data,
	input  mask_t    [1:0] mem_w_mask,
	output word_t    [1:0] mem_r_data,
	output logic     [1:0] mem_busy,
	output logic     [1:0] mem_done,
	output logic           msg_send,
	output msg_t           send_msg,
	output msg_len_t       send_len,
	input  logic           send_ready,
	input  logic           recv_valid,
	input  msg_t           recv_msg,
	input  msg_len_t       recv_len
);

	typedef enum logic [2:0]
	{
		b_idle,
		b_send,
		b_wait_send,
		b_wait_reply,
		b_finish
	} bridge_state_t;

	bridge_state_t state;
	logic          cur_port;     // Port being served
	logic          cur_write;
	logic          reply_ok;

	assign cur_write = (mem_op[cur_port] == op_write);
	assign reply_ok  = recv_valid && (recv_len == read_reply_len);
	assign msg_send  = (state == b_send) && send_ready;

	// Request stays held, so build from the live port signals
	always_comb
	begin
		if (cur_write)
		begin
			send_msg = {mem_w_data[cur_port], mem_addr[cur_port],
				req_write_base | byte_t'(mem_w_mask[cur_port])};
			send_len = write_req_len;
		end
		else
		begin
			send_msg = {32'h0, mem_addr[cur_port], req_read};
			send_len = read_req_len;
		end
	end

	always_comb
	begin
		for (int p = 0; p < 2; p++)
		begin
			mem_done[p] = (state == b_finish) && (cur_port == 1'(p));
			mem_busy[p] = (mem_op[p] != op_idle) &&
				((state == b_idle) ? (p == 1 && mem_op[0] != op_idle)
				                   : (cur_port != 1'(p)));
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state    <= b_idle;
			cur_port <= 1'b0;
		end
		else
		begin
			case (state)
				b_idle:
				begin
					if (mem_op[0] != op_idle)
					begin
						cur_port <= 1'b0;      // Port 0 has priority
						state    <= b_send;
					end
					else if (mem_op[1] != op_idle)
					begin
						cur_port <= 1'b1;
						state    <= b_send;
					end
				end
				b_send:
				begin
					if (send_ready)
						state <= cur_write ? b_finish : b_wait_send;
				end
				b_wait_send:
				begin
					if (send_ready)
						state <= b_wait_reply;  // Request fully on the line
				end
				b_wait_reply:
				begin
					if (reply_ok)
						state <= b_finish;
				end
				default:
					state <= b_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == b_wait_reply && reply_ok)
			mem_r_data[cur_port] <= recv_msg[31:0];
	end

	// Served request held until its mem_done
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		(state != b_idle) |-> (mem_op[cur_port] != op_idle));

	// Replies only for an outstanding read
	a_reply_expected: assert property (@(posedge clk) disable iff (rst)
		recv_valid |-> (state == b_wait_reply));

endmodule

`default_nettype wire

// File: design/uart_mem_top.sv
`default_nettype none

module uart_mem_top
	import soc_pkg::*;
#(
	parameter int SAMPLE_INTERVAL = 16
)
(
	input  logic           clk,
	input  logic           button,
	output logic           tx,
	input  logic           rx,
	input  mem_op_t  [1:0] mem_op,
	input  addr_t    [1:0] mem_addr,
	input  word_t    [1:0] mem_w_data,
	input  mask_t    [1:0] mem_w_mask,
	output word_t    [1:0] mem_r_data,
	output logic     [1:0] mem_busy,
	output logic     [1:0] mem_done
);

	logic     rst;
	logic     rst_delay;

	logic     tx_start;
	byte_t    tx_byte;
	logic     tx_idle;
	logic     rx_valid;
	byte_t    rx_byte;

	logic     msg_send;
	msg_t     send_msg;
	msg_len_t send_len;
	logic     send_ready;
	logic     recv_valid;
	msg_t     recv_msg;
	msg_len_t recv_len;

	// Button sets at once, release comes two clocks later
	always_ff @(posedge clk or posedge button)
	begin
		if (button)
		begin
			rst       <= 1'b1;
			rst_delay <= 1'b1;
		end
		else
		begin
			rst_delay <= 1'b0;
			rst       <= rst_delay;
		end
	end

	uart_link #(.SAMPLE_INTERVAL(SAMPLE_INTERVAL)) uart0
	(
		.clk      (clk),
		.rst      (rst),
		.tx_start (tx_start),
		.tx_byte  (tx_byte),
		.tx_idle  (tx_idle),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte),
		.tx       (tx),
		.rx       (rx)
	);

	msg_framer framer0
	(
		.clk        (clk),
		.rst        (rst),
		.msg_send   (msg_send),
		.send_msg   (send_msg),
		.send_len   (send_len),
		.send_ready (send_ready),
		.recv_valid (recv_valid),
		.recv_msg   (recv_msg),
		.recv_len   (recv_len),
		.tx_start   (tx_start),
		.tx_byte    (tx_byte),
		.tx_idle    (tx_idle),
		.rx_valid   (rx_valid),
		.rx_byte    (rx_byte)
	);

	mem_bridge bridge0
	(
		.clk        (clk),
		.rst        (rst),
		.mem_op     (mem_op),
		.mem_addr   (mem_addr),
		.mem_w_data (mem_w_data),
		.mem_w_mask (mem_w_mask),
		.mem_r_data (mem_r_data),
		.mem_busy   (mem_busy),
		.mem_done   (mem_done),
		.msg_send   (msg_send),
		.send_msg   (send_msg),
		.send_len   (send_len),
		.send_ready (send_ready),
		.recv_valid (recv_valid),
		.recv_msg   (recv_msg),
		.recv_len   (recv_len)
	);

endmodule

`default_nettype wire

// File: bench/host_model.sv
`default_nettype none

module host_model
#(
	parameter int SAMPLE_INTERVAL = 16
)
(
	input  logic clk,
	input  logic serial_in,      // From DUT tx
	output logic serial_out,     // To DUT rx
	output logic proto_error
);

	logic [31:0] mem [0:255];
	logic [7:0]  frame [0:8];
	logic [7:0]  len;
	logic [31:0] addr;
	logic [31:0] data;
	int          i;

	task automatic flag_fault(input string what);
		$display("host model fault: %s", what);
		proto_error = 1'b1;
	endtask

	// Line is sampled on the falling clock edge, away from DUT updates
	task automatic receive_byte(output logic [7:0] value);
		int b;
		@(negedge clk);
		while (serial_in !== 1'b0)
			@(negedge clk);
		repeat (SAMPLE_INTERVAL / 2) @(negedge clk);   // Middle of start bit
		if (serial_in !== 1'b0)
			flag_fault("start bit did not stay low");
		for (b = 0; b < 8; b++)
		begin
			repeat (SAMPLE_INTERVAL) @(negedge clk);
			value[b] = serial_in;                       // LSB first
		end
		repeat (SAMPLE_INTERVAL) @(negedge clk);
		if (serial_in !== 1'b1)
			flag_fault("stop bit was low");
	endtask

	task automatic send_byte(input logic [7:0] value);
		int b;
		serial_out = 1'b0;
		repeat (SAMPLE_INTERVAL) @(negedge clk);
		for (b = 0; b < 8; b++)
		begin
			serial_out = value[b];
			repeat (SAMPLE_INTERVAL) @(negedge clk);
		end
		serial_out = 1'b1;
		repeat (SAMPLE_INTERVAL) @(negedge clk);
	endtask

	initial
	begin
		serial_out  = 1'b1;
		proto_error = 1'b0;
		for (i = 0; i < 256; i++)
			mem[i] = {22'd0, i[7:0], 2'b00} ^ 32'h5a5a0000;
		forever
		begin
			receive_byte(len);
			if (len != 8'd5 && len != 8'd9)
				flag_fault($sformatf("request length %0d is neither 5 nor 9", len));
			else
			begin
				for (i = 0; i < len; i++)
					receive_byte(frame[i]);
				addr = {frame[4], frame[3], frame[2], frame[1]};
				if (len == 8'd5)
				begin
					if (frame[0] != 8'h00)
						flag_fault($sformatf("read request has opcode %h", frame[0]));
					data = mem[addr[9:2]];
					send_byte(8'd4);                    // Reply length
					for (i = 0; i < 4; i++)
						send_byte(data[i*8 +: 8]);
				end
				else
				begin
					if (frame[0][7:4] != 4'h8)
						flag_fault($sformatf("write request has opcode %h", frame[0]));
					data = {frame[8], frame[7], frame[6], frame[5]};
					for (i = 0; i < 4; i++)
						if (frame[0][i])
							mem[addr[9:2]][i*8 +: 8] = data[i*8 +: 8];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_uart_mem.sv
`default_nettype none

module tb_uart_mem
	import soc_pkg::*;
();

	localparam int SAMPLE_INTERVAL = 8;
	localparam int drive_delay     = 2;
	localparam int timeout_cycles  = 400000;  // About 60 transactions of 1500 cycles, with margin

	logic           clk;
	logic           button;
	logic           tx;
	logic           rx;
	mem_op_t  [1:0] mem_op;
	addr_t    [1:0] mem_addr;
	word_t    [1:0] mem_w_data;
	mask_t    [1:0] mem_w_mask;
	word_t    [1:0] mem_r_data;
	logic     [1:0] mem_busy;
	logic     [1:0] mem_done;
	logic           proto_error;

	word_t          shadow [0:255];
	int             cycle_count;
	int             n;
	int             rand_port;
	mem_op_t        rand_op;

	uart_mem_top #(.SAMPLE_INTERVAL(SAMPLE_INTERVAL)) dut0
	(
		.clk        (clk),
		.button     (button),
		.tx         (tx),
		.rx         (rx),
		.mem_op     (mem_op),
		.mem_addr   (mem_addr),
		.mem_w_data (mem_w_data),
		.mem_w_mask (mem_w_mask),
		.mem_r_data (mem_r_data),
		.mem_busy   (mem_busy),
		.mem_done   (mem_done)
	);

	host_model #(.SAMPLE_INTERVAL(SAMPLE_INTERVAL)) host0
	(
		.clk         (clk),
		.serial_in   (tx),
		.serial_out  (rx),
		.proto_error (proto_error)
	);

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		assert (actual === expected)
		else
		begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else
		begin
			$display("mismatch %s expected %b actual %b", name, expected, actual);
			stop_with_failure();
		end
	endtask

	function automatic word_t shadow_read(input addr_t addr);
		return shadow[addr[9:2]];
	endfunction

	task automatic shadow_write(input addr_t addr, input word_t data, input mask_t mask);
		int b;
		for (b = 0; b < 4; b++)
			if (mask[b])
				shadow[addr[9:2]][b*8 +: 8] = data[b*8 +: 8];
	endtask

	// Called just after a rising edge
	task automatic issue_request(input int port, input mem_op_t op, input addr_t addr,
		input word_t data, input mask_t mask);
		mem_op[port]     = op;
		mem_addr[port]   = addr;
		mem_w_data[port] = data;
		mem_w_mask[port] = mask;
	endtask

	task automatic wait_for_done(input int port, input string name, output word_t data);
		@(negedge clk);
		while (!mem_done[port])
		begin
			check_bit({name, " busy"}, 1'b0, mem_busy[port]);
			@(negedge clk);
		end
		check_bit({name, " other port done"}, 1'b0, mem_done[1 - port]);
		data = mem_r_data[port];
		@(posedge clk);
		#drive_delay;
		mem_op[port] = op_idle;                 // Release after the done pulse
	endtask

	task automatic run_single(input int port, input mem_op_t op, input addr_t addr,
		input word_t data, input mask_t mask, input string name);
		word_t got;
		issue_request(port, op, addr, data, mask);
		wait_for_done(port, name, got);
		if (op == op_read)
			check_word(name, shadow_read(addr), got);
		else
			shadow_write(addr, data, mask);
	endtask

	// Port 0 writes, port 1 reads the same word in the same cycle
	task automatic run_pair(input addr_t addr, input word_t data, input mask_t mask);
		word_t got;
		issue_request(0, op_write, addr, data, mask);
		issue_request(1, op_read, addr, 32'h0, 4'h0);
		@(negedge clk);
		while (!mem_done[0])
		begin
			check_bit("pair port 1 busy", 1'b1, mem_busy[1]);
			check_bit("pair port 1 done early", 1'b0, mem_done[1]);
			@(negedge clk);
		end
		check_bit("pair port 1 busy at port 0 done", 1'b1, mem_busy[1]);
		shadow_write(addr, data, mask);
		@(posedge clk);
		#drive_delay;
		mem_op[0] = op_idle;
		wait_for_done(1, "pair port 1", got);
		check_word("pair port 1 read", shadow_read(addr), got);
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycle_count);
		stop_with_failure();
	end

	initial
	begin
		wait (proto_error === 1'b1);
		$display("host model saw a malformed request frame");
		stop_with_failure();
	end

	initial
	begin
		void'($urandom(32'h600f210f));
		button     = 1'b1;
		mem_op     = {op_idle, op_idle};
		mem_addr   = '0;
		mem_w_data = '0;
		mem_w_mask = '0;
		for (n = 0; n < 256; n++)
			shadow[n] = {22'd0, n[7:0], 2'b00} ^ 32'h5a5a0000;
		repeat (3) @(posedge clk);
		#drive_delay;
		button = 1'b0;

		repeat (20)
		begin
			@(negedge clk);
			check_bit("idle tx", 1'b1, tx);
			check_word("idle busy", 32'h0, {30'd0, mem_busy});
			check_word("idle done", 32'h0, {30'd0, mem_done});
		end
		@(posedge clk);
		#drive_delay;

		run_single(0, op_read, 32'h0000_0124, 32'h0, 4'h0, "read port 0");
		run_single(1, op_write, 32'h0000_0240, 32'hdead_beef, 4'b0101, "masked write port 1");
		run_single(1, op_read, 32'h0000_0240, 32'h0, 4'h0, "read after masked write");
		run_pair(32'h0000_0380, 32'h1234_5678, 4'b0110);

		for (n = 0; n < 40; n++)
		begin
			rand_port = $urandom % 2;
			rand_op   = ($urandom % 2) ? op_write : op_read;
			run_single(rand_port, rand_op, $urandom & 32'hffff_fffc, $urandom,
				mask_t'($urandom), $sformatf("random %0d", n));
		end

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
design/soc_pkg.sv
design/uart_link.sv
design/msg_framer.sv
design/mem_bridge.sv
design/uart_mem_top.sv
bench/host_model.sv
bench/tb_uart_mem.sv
